// File: hw/biocom_pkg.sv
/* Shared timing, memory map and widths for the game subsystem.
   All RAMs share the char RAM depth; smaller regions use only the low words. */
`default_nettype none

package biocom_pkg;

    // Horizontal timing in pixels
    localparam int H_TOTAL  = 384;
    localparam int H_ACTIVE = 256;
    localparam int HS_START = 288;
    localparam int HS_END   = 320;

    // Vertical timing in lines
    localparam int V_TOTAL  = 264;
    localparam int V_ACTIVE = 224;
    localparam int VS_START = 240;
    localparam int VS_END   = 244;

    localparam int H_BITS = 9;
    localparam int V_BITS = 9;

    localparam int DATA_W    = 16;
    localparam int ADDR_W    = 13;
    localparam int CHAR_AW   = 10;
    localparam int OBJ_AW    = 7;
    localparam int OBJ_WORDS = 128;

    // Word RAM depth follows the widest address
    localparam int RAM_DEPTH = 1 << CHAR_AW;

    // CPU memory map, word addresses
    localparam int CHAR_BASE    = 'h0000;
    localparam int CHAR_WORDS   = 1 << CHAR_AW;
    localparam int OBJ_BASE     = 'h0800;
    localparam int SCROLL_BASE  = 'h0C00;
    localparam int SCROLL_WORDS = 2;
    localparam int SOUND_BASE   = 'h0C10;

    typedef enum logic [2:0] {
        REGION_CHAR,
        REGION_OBJ,
        REGION_SCROLL,
        REGION_SOUND,
        REGION_NONE
    } bus_region_e;

    typedef enum logic [1:0] {
        DMA_IDLE,
        DMA_REQ,
        DMA_COPY,
        DMA_RELEASE
    } dma_state_e;

endpackage

`default_nettype wire

// File: hw/video_timer.sv
/* Counters and strobes move only on pxl_cen.
   All strobes are registered from the next position, so they line up with h and v. */
`timescale 1ns/1ps
`default_nettype none

module video_timer import biocom_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                pxl_cen,
    output logic [H_BITS-1:0]  h,
    output logic [V_BITS-1:0]  v,
    output logic               lhbl,
    output logic               lvbl,
    output logic               hs,
    output logic               vs,
    output logic               hinit
);

    logic [H_BITS-1:0] h_nxt;
    logic [V_BITS-1:0] v_nxt;

    // Next position, line wrap bumps the line counter
    always_comb begin
        h_nxt = h + 1'b1;
        v_nxt = v;
        if (h == H_BITS'(H_TOTAL - 1)) begin
            h_nxt = '0;
            if (v == V_BITS'(V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = v + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            h     <= '0;
            v     <= '0;
            lhbl  <= 1'b1;
            lvbl  <= 1'b1;
            hs    <= 1'b0;
            vs    <= 1'b0;
            hinit <= 1'b1;
        end else if (pxl_cen) begin
            h <= h_nxt;
            v <= v_nxt;
            // Blanking is active low
            lhbl  <= h_nxt < H_BITS'(H_ACTIVE);
            lvbl  <= v_nxt < V_BITS'(V_ACTIVE);
            hs    <= (h_nxt >= H_BITS'(HS_START)) && (h_nxt < H_BITS'(HS_END));
            vs    <= (v_nxt >= V_BITS'(VS_START)) && (v_nxt < V_BITS'(VS_END));
            // Start of line, one pixel wide
            hinit <= h_nxt == '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/word_ram.sv
/* Dual-read word RAM, one write port, registered reads on both ports.
   A read of the word being written returns the old contents. */
`timescale 1ns/1ps
`default_nettype none

module word_ram import biocom_pkg::*; (
    input  wire                clk,
    input  wire                wr_en,
    input  wire [CHAR_AW-1:0]  wr_addr,
    input  wire [DATA_W-1:0]   wr_data,
    input  wire [CHAR_AW-1:0]  rd_a_addr,
    input  wire [CHAR_AW-1:0]  rd_b_addr,
    output logic [DATA_W-1:0]  rd_a_data,
    output logic [DATA_W-1:0]  rd_b_data
);

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // Port A for the writer side, port B for video or DMA
        rd_a_data <= mem[rd_a_addr];
        rd_b_data <= mem[rd_b_addr];
    end

endmodule

`default_nettype wire

// File: hw/main_bus.sv
/* CPU must hold cs, wr, addr and din until busy is low; RAM reads take one extra cycle.
   All CPU accesses stall while the object DMA owns the bus. */
`timescale 1ns/1ps
`default_nettype none

module main_bus import biocom_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                cpu_cs,
    input  wire                cpu_wr,
    input  wire [ADDR_W-1:0]   cpu_addr,
    input  wire [DATA_W-1:0]   cpu_din,
    output logic [DATA_W-1:0]  cpu_dout,
    output logic               cpu_busy,
    input  wire [CHAR_AW-1:0]  char_addr,
    output logic [DATA_W-1:0]  char_data,
    input  wire                bus_req,
    output logic               bus_ack,
    input  wire [OBJ_AW-1:0]   obj_addr,
    output logic [DATA_W-1:0]  oram_dout,
    output logic [DATA_W-1:0]  scr_hpos,
    output logic [DATA_W-1:0]  scr_vpos,
    output logic [DATA_W-1:0]  snd_latch,
    output logic               snd_req,
    input  wire                snd_ack
);

    bus_region_e        region;
    logic               ram_rd;
    logic               snd_wr;
    logic               rd_wait;
    logic               cpu_done;
    logic               grant;
    logic               char_we;
    logic               obj_we;
    logic [CHAR_AW-1:0] obj_cpu_addr;
    logic [CHAR_AW-1:0] obj_dma_addr;
    logic [DATA_W-1:0]  char_cpu_q;
    logic [DATA_W-1:0]  obj_cpu_q;
    logic [DATA_W-1:0]  rd_mux;
    logic [DATA_W-1:0]  dout_q;

    // Address decode
    always_comb begin
        if (cpu_addr < ADDR_W'(CHAR_BASE + CHAR_WORDS)) begin
            region = REGION_CHAR;
        end else if (cpu_addr >= ADDR_W'(OBJ_BASE)
                     && cpu_addr < ADDR_W'(OBJ_BASE + OBJ_WORDS)) begin
            region = REGION_OBJ;
        end else if (cpu_addr >= ADDR_W'(SCROLL_BASE)
                     && cpu_addr < ADDR_W'(SCROLL_BASE + SCROLL_WORDS)) begin
            region = REGION_SCROLL;
        end else if (cpu_addr == ADDR_W'(SOUND_BASE)) begin
            region = REGION_SOUND;
        end else begin
            region = REGION_NONE;
        end
    end

    assign ram_rd = cpu_cs && !cpu_wr && (region == REGION_CHAR || region == REGION_OBJ);
    assign snd_wr = cpu_cs && cpu_wr && region == REGION_SOUND;

    // Stall on DMA ownership, first RAM read cycle, or sound back-pressure
    assign cpu_busy = bus_ack ? cpu_cs
                    : ((ram_rd && !rd_wait) || (snd_wr && (snd_req || snd_ack)));
    assign cpu_done = cpu_cs && !cpu_busy;

    // Grant only on an idle cycle with no RAM read in flight
    assign grant = bus_req && !bus_ack && !cpu_done && !rd_wait;

    assign char_we      = cpu_done && cpu_wr && region == REGION_CHAR;
    assign obj_we       = cpu_done && cpu_wr && region == REGION_OBJ;
    assign obj_cpu_addr = CHAR_AW'(cpu_addr[OBJ_AW-1:0]);
    assign obj_dma_addr = CHAR_AW'(obj_addr);

    always_comb begin
        case (region)
            REGION_CHAR:   rd_mux = char_cpu_q;
            REGION_OBJ:    rd_mux = obj_cpu_q;
            REGION_SCROLL: rd_mux = cpu_addr[0] ? scr_vpos : scr_hpos;
            REGION_SOUND:  rd_mux = snd_latch;
            default:       rd_mux = '1;
        endcase
    end

    // Live data on the completing cycle, held value otherwise
    assign cpu_dout = (cpu_done && !cpu_wr) ? rd_mux : dout_q;

    always_ff @(posedge clk) begin
        if (cpu_done && !cpu_wr) begin
            dout_q <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_wait   <= 1'b0;
            bus_ack   <= 1'b0;
            snd_req   <= 1'b0;
            snd_latch <= '0;
            scr_hpos  <= '0;
            scr_vpos  <= '0;
        end else begin
            rd_wait <= (grant || bus_ack) ? 1'b0 : (ram_rd && !rd_wait);

            if (grant) begin
                bus_ack <= 1'b1;
            end else if (!bus_req) begin
                bus_ack <= 1'b0;
            end

            if (cpu_done && cpu_wr && region == REGION_SCROLL) begin
                if (cpu_addr[0]) begin
                    scr_vpos <= cpu_din;
                end else begin
                    scr_hpos <= cpu_din;
                end
            end

            // Sound latch, req drops once the sound CPU acks
            if (cpu_done && snd_wr) begin
                snd_latch <= cpu_din;
                snd_req   <= 1'b1;
            end else if (snd_req && snd_ack) begin
                snd_req <= 1'b0;
            end
        end
    end

    word_ram u_char_ram (
        .clk       ( clk          ),
        .wr_en     ( char_we      ),
        .wr_addr   ( cpu_addr[CHAR_AW-1:0] ),
        .wr_data   ( cpu_din      ),
        .rd_a_addr ( cpu_addr[CHAR_AW-1:0] ),
        .rd_b_addr ( char_addr    ),
        .rd_a_data ( char_cpu_q   ),
        .rd_b_data ( char_data    )
    );

    word_ram u_obj_ram (
        .clk       ( clk          ),
        .wr_en     ( obj_we       ),
        .wr_addr   ( obj_cpu_addr ),
        .wr_data   ( cpu_din      ),
        .rd_a_addr ( obj_cpu_addr ),
        .rd_b_addr ( obj_dma_addr ),
        .rd_a_data ( obj_cpu_q    ),
        .rd_b_data ( oram_dout    )
    );

endmodule

`default_nettype wire

// File: hw/obj_dma.sv
/* Copies the whole object table once per frame at the start of vertical blank.
   The sprite side reads the buffer, which changes only during the copy. */
`timescale 1ns/1ps
`default_nettype none

module obj_dma import biocom_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                lvbl,
    output logic               bus_req,
    input  wire                bus_ack,
    output logic [OBJ_AW-1:0]  obj_addr,
    input  wire [DATA_W-1:0]   oram_dout,
    input  wire [OBJ_AW-1:0]   obj_rd_addr,
    output logic [DATA_W-1:0]  obj_rd_data
);

    dma_state_e         state;
    logic               lvbl_l;
    logic               vb_start;
    logic [OBJ_AW:0]    cnt;
    logic               wr_pend;
    logic [OBJ_AW-1:0]  wr_addr_d;
    logic [CHAR_AW-1:0] buf_wr_addr;

    assign vb_start    = lvbl_l && !lvbl;
    assign bus_req     = state == DMA_REQ || state == DMA_COPY;
    assign obj_addr    = cnt[OBJ_AW-1:0];
    assign buf_wr_addr = CHAR_AW'(wr_addr_d);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= DMA_IDLE;
            lvbl_l  <= 1'b1;
            cnt     <= '0;
            wr_pend <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            // Object RAM data arrives one cycle after its address
            wr_pend <= state == DMA_COPY && cnt < (OBJ_AW+1)'(OBJ_WORDS);
            case (state)
                DMA_IDLE: begin
                    if (vb_start) begin
                        state <= DMA_REQ;
                    end
                end
                DMA_REQ: begin
                    if (bus_ack) begin
                        state <= DMA_COPY;
                        cnt   <= '0;
                    end
                end
                DMA_COPY: begin
                    cnt <= cnt + 1'b1;
                    // Extra cycle for the last word to land
                    if (cnt == (OBJ_AW+1)'(OBJ_WORDS)) begin
                        state <= DMA_RELEASE;
                    end
                end
                default: begin
                    if (!bus_ack) begin
                        state <= DMA_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_d <= obj_addr;
    end

    word_ram u_obj_buf (
        .clk       ( clk         ),
        .wr_en     ( wr_pend     ),
        .wr_addr   ( buf_wr_addr ),
        .wr_data   ( oram_dout   ),
        .rd_a_addr ( buf_wr_addr ),
        .rd_b_addr ( CHAR_AW'(obj_rd_addr) ),
        .rd_a_data (             ),
        .rd_b_data ( obj_rd_data )
    );

endmodule

`default_nettype wire

// File: hw/biocom_game.sv
/* Game subsystem without CPUs or renderers; those attach at the ports.
   Sound latch follows a four-phase snd_req/snd_ack handshake. */
`timescale 1ns/1ps
`default_nettype none

module biocom_game import biocom_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                pxl_cen,
    // CPU port
    input  wire                cpu_cs,
    input  wire                cpu_wr,
    input  wire [ADDR_W-1:0]   cpu_addr,
    input  wire [DATA_W-1:0]   cpu_din,
    output wire [DATA_W-1:0]   cpu_dout,
    output wire                cpu_busy,
    // Video side
    input  wire [CHAR_AW-1:0]  char_addr,
    output wire [DATA_W-1:0]   char_data,
    input  wire [OBJ_AW-1:0]   obj_rd_addr,
    output wire [DATA_W-1:0]   obj_rd_data,
    output wire [DATA_W-1:0]   scr_hpos,
    output wire [DATA_W-1:0]   scr_vpos,
    // Sound CPU
    output wire [DATA_W-1:0]   snd_latch,
    output wire                snd_req,
    input  wire                snd_ack,
    // Timing
    output wire [H_BITS-1:0]   h,
    output wire [V_BITS-1:0]   v,
    output wire                lhbl,
    output wire                lvbl,
    output wire                hs,
    output wire                vs,
    output wire                hinit
);

    wire               bus_req;
    wire               bus_ack;
    wire [OBJ_AW-1:0]  obj_addr;
    wire [DATA_W-1:0]  oram_dout;

    video_timer u_timer (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .pxl_cen ( pxl_cen ),
        .h       ( h       ),
        .v       ( v       ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .hinit   ( hinit   )
    );

    main_bus u_main (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cpu_cs    ( cpu_cs    ),
        .cpu_wr    ( cpu_wr    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_din   ( cpu_din   ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_busy  ( cpu_busy  ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .bus_req   ( bus_req   ),
        .bus_ack   ( bus_ack   ),
        .obj_addr  ( obj_addr  ),
        .oram_dout ( oram_dout ),
        .scr_hpos  ( scr_hpos  ),
        .scr_vpos  ( scr_vpos  ),
        .snd_latch ( snd_latch ),
        .snd_req   ( snd_req   ),
        .snd_ack   ( snd_ack   )
    );

    // Object DMA runs off the vertical blank edge
    obj_dma u_dma (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .lvbl        ( lvbl        ),
        .bus_req     ( bus_req     ),
        .bus_ack     ( bus_ack     ),
        .obj_addr    ( obj_addr    ),
        .oram_dout   ( oram_dout   ),
        .obj_rd_addr ( obj_rd_addr ),
        .obj_rd_data ( obj_rd_data )
    );

endmodule

`default_nettype wire

// File: bench/biocom_game_properties.sv
/* Handshake and stall assertions, bound into every main_bus instance.
   The DMA stall check treats any move of obj_addr as copy activity. */
`timescale 1ns/1ps
`default_nettype none

module biocom_game_properties import biocom_pkg::*; (
    input wire               clk,
    input wire               reset,
    input wire               cpu_cs,
    input wire               cpu_busy,
    input wire               bus_req,
    input wire               bus_ack,
    input wire [OBJ_AW-1:0]  obj_addr,
    input wire               snd_req,
    input wire               snd_ack,
    input wire [DATA_W-1:0]  snd_latch
);

    int fail_count = 0;

    // Object DMA grant
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(bus_ack) |-> bus_req)
        else begin
            $error("bus_ack rose while bus_req was low");
            fail_count++;
        end

    req_held_until_ack: assert property (@(posedge clk) disable iff (reset)
        bus_req && !bus_ack |=> bus_req)
        else begin
            $error("bus_req dropped before bus_ack");
            fail_count++;
        end

    ack_falls_after_req: assert property (@(posedge clk) disable iff (reset)
        $fell(bus_ack) |-> !bus_req)
        else begin
            $error("bus_ack fell while bus_req was high");
            fail_count++;
        end

    // CPU locked out while the DMA steps through object RAM
    cpu_stalled_by_dma: assert property (@(posedge clk) disable iff (reset)
        cpu_cs && $changed(obj_addr) |-> cpu_busy)
        else begin
            $error("CPU access not stalled during the object copy");
            fail_count++;
        end

    // Sound latch
    snd_held_until_ack: assert property (@(posedge clk) disable iff (reset)
        snd_req && !snd_ack |=> snd_req && $stable(snd_latch))
        else begin
            $error("snd_req or snd_latch changed before snd_ack");
            fail_count++;
        end

    snd_no_req_during_ack: assert property (@(posedge clk) disable iff (reset)
        snd_ack && !snd_req |=> !snd_req)
        else begin
            $error("snd_req raised again while snd_ack was still high");
            fail_count++;
        end

endmodule

bind main_bus biocom_game_properties u_props (
    .clk       ( clk       ),
    .reset     ( reset     ),
    .cpu_cs    ( cpu_cs    ),
    .cpu_busy  ( cpu_busy  ),
    .bus_req   ( bus_req   ),
    .bus_ack   ( bus_ack   ),
    .obj_addr  ( obj_addr  ),
    .snd_req   ( snd_req   ),
    .snd_ack   ( snd_ack   ),
    .snd_latch ( snd_latch )
);

`default_nettype wire

// File: bench/biocom_game_tb.sv
/* Stands in for the main CPU and the sound CPU, with pxl_cen held high.
   Covers about two video frames; object RAM reads rely on the whole table being written. */
`timescale 1ns/1ps
`default_nettype none

module biocom_game_tb import biocom_pkg::*; ();

    localparam int     CLK_PERIOD  = 20;
    localparam int     DRIVE_DELAY = 2;
    localparam longint WATCHDOG_NS = (3 * H_TOTAL * V_TOTAL + 20000) * CLK_PERIOD;

    logic               clk;
    logic               reset;
    logic               pxl_cen;
    logic               cpu_cs;
    logic               cpu_wr;
    logic [ADDR_W-1:0]  cpu_addr;
    logic [DATA_W-1:0]  cpu_din;
    wire  [DATA_W-1:0]  cpu_dout;
    wire                cpu_busy;
    logic [CHAR_AW-1:0] char_addr;
    wire  [DATA_W-1:0]  char_data;
    logic [OBJ_AW-1:0]  obj_rd_addr;
    wire  [DATA_W-1:0]  obj_rd_data;
    wire  [DATA_W-1:0]  scr_hpos;
    wire  [DATA_W-1:0]  scr_vpos;
    wire  [DATA_W-1:0]  snd_latch;
    wire                snd_req;
    logic               snd_ack;
    wire  [H_BITS-1:0]  h;
    wire  [V_BITS-1:0]  v;
    wire                lhbl;
    wire                lvbl;
    wire                hs;
    wire                vs;
    wire                hinit;

    // Expected memory contents
    logic [DATA_W-1:0]  char_mem [CHAR_WORDS];
    logic [DATA_W-1:0]  obj_mem [OBJ_WORDS];
    logic [DATA_W-1:0]  buf_model [OBJ_WORDS];
    logic [DATA_W-1:0]  hpos_m;
    logic [DATA_W-1:0]  vpos_m;
    logic [DATA_W-1:0]  latch_m;

    integer             seed = 46080;
    int                 err_count = 0;
    int                 stall_cycles = 0;
    int                 dma_done_count = 0;
    int                 frame_count = 0;
    int                 snd_acks = 0;
    int                 prev_h;
    int                 prev_v;
    logic               prev_valid = 1'b0;
    logic               timer_on = 1'b0;
    logic               ack_seen = 1'b0;
    logic               snd_go;
    logic [4:0]         timing_exp;
    logic [DATA_W-1:0]  snd_rx [$];
    int                 char_addrs [$];

    biocom_game dut0 (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .pxl_cen     ( pxl_cen     ),
        .cpu_cs      ( cpu_cs      ),
        .cpu_wr      ( cpu_wr      ),
        .cpu_addr    ( cpu_addr    ),
        .cpu_din     ( cpu_din     ),
        .cpu_dout    ( cpu_dout    ),
        .cpu_busy    ( cpu_busy    ),
        .char_addr   ( char_addr   ),
        .char_data   ( char_data   ),
        .obj_rd_addr ( obj_rd_addr ),
        .obj_rd_data ( obj_rd_data ),
        .scr_hpos    ( scr_hpos    ),
        .scr_vpos    ( scr_vpos    ),
        .snd_latch   ( snd_latch   ),
        .snd_req     ( snd_req     ),
        .snd_ack     ( snd_ack     ),
        .h           ( h           ),
        .v           ( v           ),
        .lhbl        ( lhbl        ),
        .lvbl        ( lvbl        ),
        .hs          ( hs          ),
        .vs          ( vs          ),
        .hinit       ( hinit       )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run hung: the DUT did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    // Bound handshake assertions
    always @(negedge clk) begin
        if (dut0.u_main.u_props.fail_count != 0) begin
            $display("A bound handshake assertion failed at %0t ns", $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "Assertion failure");
        end
    end

    // {lhbl, lvbl, hs, vs, hinit} for a screen position
    function automatic logic [4:0] expected_timing(input int hpos, input int vpos);
        logic [4:0] t;
        t[4] = hpos < H_ACTIVE;
        t[3] = vpos < V_ACTIVE;
        t[2] = hpos >= HS_START && hpos < HS_END;
        t[1] = vpos >= VS_START && vpos < VS_END;
        t[0] = hpos == 0;
        return t;
    endfunction

    function automatic bus_region_e decode_region(input int addr);
        if (addr >= CHAR_BASE && addr < CHAR_BASE + CHAR_WORDS) begin
            return REGION_CHAR;
        end else if (addr >= OBJ_BASE && addr < OBJ_BASE + OBJ_WORDS) begin
            return REGION_OBJ;
        end else if (addr >= SCROLL_BASE && addr < SCROLL_BASE + SCROLL_WORDS) begin
            return REGION_SCROLL;
        end else if (addr == SOUND_BASE) begin
            return REGION_SOUND;
        end
        return REGION_NONE;
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input int addr);
        case (decode_region(addr))
            REGION_CHAR:   return char_mem[addr - CHAR_BASE];
            REGION_OBJ:    return obj_mem[addr - OBJ_BASE];
            REGION_SCROLL: return (addr == SCROLL_BASE + 1) ? vpos_m : hpos_m;
            REGION_SOUND:  return latch_m;
            default:       return '1;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] expected_buffer(input int idx);
        return buf_model[idx];
    endfunction

    function automatic void model_write(input int addr, input logic [DATA_W-1:0] data);
        case (decode_region(addr))
            REGION_CHAR:   char_mem[addr - CHAR_BASE] = data;
            REGION_OBJ:    obj_mem[addr - OBJ_BASE] = data;
            REGION_SCROLL: begin
                if (addr == SCROLL_BASE + 1) begin
                    vpos_m = data;
                end else begin
                    hpos_m = data;
                end
            end
            REGION_SOUND:  latch_m = data;
            default:       ;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Called at the drive point, returns at the drive point after one idle cycle
    task automatic bus_access(input logic wr, input int addr, input logic [DATA_W-1:0] data,
                              output logic [DATA_W-1:0] rdata);
        cpu_cs   = 1'b1;
        cpu_wr   = wr;
        cpu_addr = ADDR_W'(addr);
        cpu_din  = data;
        @(negedge clk);
        while (cpu_busy) begin
            stall_cycles++;
            @(negedge clk);
        end
        rdata = cpu_dout;
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_cs = 1'b0;
        cpu_wr = 1'b0;
        // Idle cycle gives a pending DMA request its grant
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic write_word(input int addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        bus_access(1'b1, addr, data, unused);
        model_write(addr, data);
    endtask

    task automatic read_word(input int addr);
        logic [DATA_W-1:0] rdata;
        bus_access(1'b0, addr, '0, rdata);
        check($sformatf("cpu_dout @%03h", addr), expected_read(addr), rdata);
    endtask

    task automatic read_char_port(input int idx);
        char_addr = CHAR_AW'(idx);
        @(posedge clk);
        @(negedge clk);
        check($sformatf("char_data @%03h", idx), char_mem[idx], char_data);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic compare_obj_buffer();
        int i;
        for (i = 0; i < OBJ_WORDS; i++) begin
            obj_rd_addr = OBJ_AW'(i);
            @(posedge clk);
            @(negedge clk);
            check($sformatf("obj_rd_data @%02h", i), expected_buffer(i), obj_rd_data);
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic wait_lvbl(input logic level);
        @(negedge clk);
        while (lvbl !== level) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_dma_done(input int count);
        @(negedge clk);
        while (dma_done_count < count) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Timer compare, every cycle after reset
    always @(negedge clk) begin
        if (timer_on) begin
            timing_exp = expected_timing(h, v);
            check("lhbl", timing_exp[4], lhbl);
            check("lvbl", timing_exp[3], lvbl);
            check("hs", timing_exp[2], hs);
            check("vs", timing_exp[1], vs);
            check("hinit", timing_exp[0], hinit);
            if (prev_valid) begin
                if (prev_h == H_TOTAL - 1) begin
                    check("h", 0, h);
                    check("v", (prev_v == V_TOTAL - 1) ? 0 : prev_v + 1, v);
                end else begin
                    check("h", prev_h + 1, h);
                    check("v", prev_v, v);
                end
                if (prev_v == V_TOTAL - 1 && v == 0) begin
                    frame_count++;
                end
            end
            prev_h     = h;
            prev_v     = v;
            prev_valid = 1'b1;
        end
    end

    // Completed DMA handshakes, counted on bus_ack falling
    always @(negedge clk) begin
        ack_seen <= dut0.u_main.bus_ack;
        if (ack_seen && !dut0.u_main.bus_ack) begin
            dma_done_count <= dma_done_count + 1;
        end
    end

    // Sound CPU, acks only while snd_go is set
    initial begin
        forever begin
            @(negedge clk);
            if (snd_go && snd_req) begin
                snd_rx.push_back(snd_latch);
                @(posedge clk);
                #DRIVE_DELAY;
                snd_ack = 1'b1;
                @(negedge clk);
                while (snd_req) begin
                    @(negedge clk);
                end
                @(posedge clk);
                #DRIVE_DELAY;
                snd_ack = 1'b0;
                snd_acks++;
            end
        end
    end

    initial begin
        int i;
        int addr;
        logic [DATA_W-1:0] d1;
        logic [DATA_W-1:0] d2;

        reset       = 1'b1;
        pxl_cen     = 1'b1;
        cpu_cs      = 1'b0;
        cpu_wr      = 1'b0;
        cpu_addr    = '0;
        cpu_din     = '0;
        char_addr   = '0;
        obj_rd_addr = '0;
        snd_ack     = 1'b0;
        snd_go      = 1'b0;
        hpos_m      = '0;
        vpos_m      = '0;
        latch_m     = '0;
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        reset    = 1'b0;
        timer_on = 1'b1;

        // Registers clear on reset
        read_word(SCROLL_BASE);
        read_word(SCROLL_BASE + 1);
        read_word(SOUND_BASE);

        // Char RAM through the CPU and the video port
        for (i = 0; i < 24; i++) begin
            addr = $random(seed) & (CHAR_WORDS - 1);
            write_word(CHAR_BASE + addr, DATA_W'($random(seed)));
            char_addrs.push_back(addr);
        end
        for (i = 0; i < char_addrs.size(); i++) begin
            read_word(CHAR_BASE + char_addrs[i]);
            read_char_port(char_addrs[i]);
        end
        write_word('h0C02, 16'h1234);
        read_word('h0400);
        read_word('h0880);
        read_word('h0C02);
        read_word('h0C11);
        read_word('h1FFF);

        // Scroll registers
        write_word(SCROLL_BASE, DATA_W'($random(seed)));
        write_word(SCROLL_BASE + 1, DATA_W'($random(seed)));
        check("scr_hpos", hpos_m, scr_hpos);
        check("scr_vpos", vpos_m, scr_vpos);
        read_word(SCROLL_BASE);
        read_word(SCROLL_BASE + 1);

        // Sound latch, then a second write held off by the handshake
        d1 = DATA_W'($random(seed));
        d2 = DATA_W'($random(seed));
        write_word(SOUND_BASE, d1);
        check("snd_req", 1, snd_req);
        check("snd_latch", d1, snd_latch);
        read_word(SOUND_BASE);
        fork
            write_word(SOUND_BASE, d2);
            begin
                repeat (20) begin
                    @(negedge clk);
                    check("cpu_busy", 1, cpu_busy);
                end
                @(posedge clk);
                #DRIVE_DELAY;
                snd_go = 1'b1;
            end
        join
        check("snd_acks", 1, snd_acks);
        check("snd_latch", d2, snd_latch);
        while (snd_acks < 2) begin
            @(negedge clk);
        end
        check("snd_rx[0]", d1, snd_rx[0]);
        check("snd_rx[1]", d2, snd_rx[1]);

        // Object table copied in the first vertical blank
        for (i = 0; i < OBJ_WORDS; i++) begin
            write_word(OBJ_BASE + i, DATA_W'($random(seed)));
        end
        for (i = 0; i < OBJ_WORDS; i++) begin
            read_word(OBJ_BASE + i);
        end
        wait_lvbl(1'b0);
        wait_dma_done(1);
        buf_model = obj_mem;
        wait_lvbl(1'b1);
        compare_obj_buffer();

        // New table during active display stays out of the buffer
        for (i = 0; i < OBJ_WORDS; i++) begin
            write_word(OBJ_BASE + i, DATA_W'($random(seed)));
        end
        compare_obj_buffer();

        // Accesses racing the DMA grant at the start of vertical blank
        wait_lvbl(1'b0);
        stall_cycles = 0;
        write_word(CHAR_BASE + 7, DATA_W'($random(seed)));
        read_word(CHAR_BASE + 7);
        write_word(SCROLL_BASE, DATA_W'($random(seed)));
        read_word(SCROLL_BASE);
        read_word(OBJ_BASE + 5);
        read_word('h1000);
        check("stall_cycles >= OBJ_WORDS", 1, stall_cycles >= OBJ_WORDS);
        wait_dma_done(2);
        buf_model = obj_mem;
        compare_obj_buffer();

        check("frame_count >= 1", 1, frame_count >= 1);
        if (err_count == 0 && dut0.u_main.u_props.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Assertion failures in the bound handshake checks");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: biocom_game.f
hw/biocom_pkg.sv
hw/video_timer.sv
hw/word_ram.sv
hw/main_bus.sv
hw/obj_dma.sv
hw/biocom_game.sv
bench/biocom_game_properties.sv
bench/biocom_game_tb.sv
